// File: hdl/qla_bus_pkg.sv
`default_nettype none

package qla_bus_pkg;

    // ------------------------------------------------------------
    // register space geometry
    // ------------------------------------------------------------
    localparam int ADDR_W   = 16;           // host quadlet address
    localparam int DATA_W   = 32;
    localparam int SPACE_W  = 4;            // adr[15:12] selects the space
    localparam int CHAN_LSB = 4;            // adr[7:4] selects the channel
    localparam int CHAN_W   = 4;
    localparam int OFF_W    = 4;            // adr[3:0] register within channel

    localparam logic [SPACE_W-1:0] ADDR_BOARD = 4'h0;   // only mapped space

    // per-axis offsets, channels 1..4
    localparam logic [OFF_W-1:0] OFF_ADC_DATA = 4'd0;   // current feedback
    localparam logic [OFF_W-1:0] OFF_DAC_CTRL = 4'd1;   // current command
    localparam logic [OFF_W-1:0] OFF_ENC_LOAD = 4'd3;   // encoder preload
    localparam logic [OFF_W-1:0] OFF_ENC_DATA = 4'd4;   // encoder count

    // channel 0 offsets
    localparam logic [OFF_W-1:0] OFF_STATUS = 4'd0;
    localparam logic [OFF_W-1:0] OFF_HW_ID  = 4'd1;

    localparam logic [DATA_W-1:0] HW_ID = 32'h514c_4131;  // ascii QLA1

    // ------------------------------------------------------------
    // status register layout
    // ------------------------------------------------------------
    localparam int ST_AMP_EN_LSB   = 0;     // amp enables, one per axis
    localparam int ST_SAFETY_LSB   = 8;     // safety disables on read
    localparam int ST_AMP_MASK_LSB = 8;     // same bits act as amp mask on write
    localparam int ST_PWR_MASK     = 18;
    localparam int ST_PWR_EN       = 19;
    localparam int ST_BOARD_ID_LSB = 24;
    localparam int BOARD_ID_W      = 4;     // rotary switch

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    // qualified write toward one channel
    typedef struct packed {
        logic              en;
        logic [OFF_W-1:0]  offset;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

endpackage

`default_nettype wire

// File: hdl/qla_axis_pkg.sv
`default_nettype none

package qla_axis_pkg;

    // ------------------------------------------------------------
    // axis datapath types
    // ------------------------------------------------------------
    localparam int NUM_AXES = 4;            // one QLA drives four motors

    // current words
    localparam int CUR_W = 16;              // adc and dac resolution

    // offset binary, midscale is zero current
    typedef logic [CUR_W-1:0] cur_word_t;

    localparam cur_word_t CUR_MID = 16'h8000;

    // quadrature count
    localparam int ENC_W = 24;              // wraps modulo 2^24

    typedef logic [ENC_W-1:0] enc_count_t;

    // one bit per axis, bit 0 is axis 1
    typedef logic [NUM_AXES-1:0] axis_vec_t;

endpackage

`default_nettype wire

// File: hdl/reg_bus_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module reg_bus_ctrl (
    input  wire                             sysclk,
    input  wire                             rst,
    input  wire qla_bus_pkg::wb_req_t       wb_req,
    input  wire qla_axis_pkg::cur_word_t    cur_fb [qla_axis_pkg::NUM_AXES],
    input  wire [qla_bus_pkg::DATA_W-1:0]   board_rdata,
    input  wire [qla_bus_pkg::DATA_W-1:0]   cmd_rdata [qla_axis_pkg::NUM_AXES],
    input  wire qla_axis_pkg::enc_count_t   count_rdata [qla_axis_pkg::NUM_AXES],
    output qla_bus_pkg::wb_rsp_t            wb_rsp,
    output qla_bus_pkg::reg_wr_t            wr [qla_axis_pkg::NUM_AXES+1]
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    localparam int AXIS_W = $clog2(NUM_AXES);

    logic [SPACE_W-1:0] space;
    logic [CHAN_W-1:0]  chan;
    logic [OFF_W-1:0]   offset;
    logic [AXIS_W-1:0]  axis_idx;
    logic               space_hit;
    logic               axis_hit;
    logic               req_vld;
    logic               ack_nxt;
    logic               ack_q;
    logic               done_q;         // access acked, waiting for stb low
    logic [DATA_W-1:0]  rd_mux;
    logic [DATA_W-1:0]  rdat_q;

    // ------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------
    assign space     = wb_req.adr[ADDR_W-1 -: SPACE_W];
    assign chan      = wb_req.adr[CHAN_LSB +: CHAN_W];
    assign offset    = wb_req.adr[OFF_W-1:0];
    assign axis_idx  = AXIS_W'(chan - 4'd1);        // channel 1 is axis index 0
    assign space_hit = (space == ADDR_BOARD);
    assign axis_hit  = (chan != '0) && (chan <= NUM_AXES);

    // one ack per access, the cycle after the first sample
    assign req_vld = wb_req.cyc & wb_req.stb;
    assign ack_nxt = req_vld & ~ack_q & ~done_q;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q  <= ack_nxt;
            done_q <= req_vld & (done_q | ack_q);   // released when stb drops
        end
    end

    // write strobes, qualified per channel, land with the ack edge
    always_comb begin
        for (int ch = 0; ch <= NUM_AXES; ch++) begin
            wr[ch].en     = ack_nxt && wb_req.we && space_hit && (chan == CHAN_W'(ch));
            wr[ch].offset = offset;
            wr[ch].data   = wb_req.dat;
        end
    end

    // ------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------
    always_comb begin
        rd_mux = '0;                                // unmapped reads as zero
        if (space_hit && chan == '0) begin
            case (offset)
                OFF_STATUS: rd_mux = board_rdata;
                OFF_HW_ID:  rd_mux = HW_ID;
                default:    rd_mux = '0;
            endcase
        end else if (space_hit && axis_hit) begin
            case (offset)
                OFF_ADC_DATA: rd_mux = DATA_W'(cur_fb[axis_idx]);    // raw feedback
                OFF_DAC_CTRL: rd_mux = cmd_rdata[axis_idx];
                OFF_ENC_DATA: rd_mux = DATA_W'(count_rdata[axis_idx]);
                default:      rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (ack_nxt && !wb_req.we) begin
            rdat_q <= rd_mux;                       // valid alongside ack
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rdat_q};

    // each access acked once, master must drop stb before the next
    a_ack_single: assert property (@(posedge sysclk) disable iff (rst)
        ack_q |=> !ack_q);

endmodule

`default_nettype wire

// File: hdl/board_regs.sv
`timescale 1ns/10ps
`default_nettype none

module board_regs (
    input  wire                                     sysclk,
    input  wire                                     rst,
    input  wire qla_bus_pkg::reg_wr_t               wr,
    input  wire [qla_bus_pkg::BOARD_ID_W-1:0]       board_id,
    input  wire qla_axis_pkg::axis_vec_t            safety_disable,
    output logic [qla_bus_pkg::DATA_W-1:0]          rdata,
    output qla_axis_pkg::axis_vec_t                 amp_enable,
    output logic                                    pwr_enable,
    output qla_axis_pkg::axis_vec_t                 clear_disable
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    axis_vec_t amp_en_q;            // commanded amp enables
    logic      pwr_en_q;            // commanded board power
    axis_vec_t clr_q;               // one-cycle clear toward the safety latches
    logic      st_wr;
    axis_vec_t wr_mask;
    axis_vec_t wr_amp;
    logic      pwr_on_wr;

    // ------------------------------------------------------------
    // status write decode
    // ------------------------------------------------------------
    assign st_wr     = wr.en && (wr.offset == OFF_STATUS);
    assign wr_mask   = wr.data[ST_AMP_MASK_LSB +: NUM_AXES];
    assign wr_amp    = wr.data[ST_AMP_EN_LSB +: NUM_AXES];
    assign pwr_on_wr = wr.data[ST_PWR_MASK] && wr.data[ST_PWR_EN];   // power turned on

    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_en_q <= '0;
            pwr_en_q <= 1'b0;
            clr_q    <= '0;
        end else begin
            clr_q <= '0;
            if (st_wr) begin
                // only masked amp bits move
                amp_en_q <= (amp_en_q & ~wr_mask) | (wr_amp & wr_mask);
                if (wr.data[ST_PWR_MASK]) begin
                    pwr_en_q <= wr.data[ST_PWR_EN];
                end
                // enabling an amp or the power rearms the trip
                clr_q <= (wr_amp & wr_mask) | {NUM_AXES{pwr_on_wr}};
            end
        end
    end

    // ------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------
    assign amp_enable    = amp_en_q & ~safety_disable & {NUM_AXES{pwr_en_q}};
    assign pwr_enable    = pwr_en_q;
    assign clear_disable = clr_q;

    // status word as the host sees it
    always_comb begin
        rdata                                 = '0;
        rdata[ST_AMP_EN_LSB +: NUM_AXES]      = amp_enable;     // effective enables
        rdata[ST_SAFETY_LSB +: NUM_AXES]      = safety_disable;
        rdata[ST_PWR_EN]                      = pwr_en_q;
        rdata[ST_BOARD_ID_LSB +: BOARD_ID_W]  = board_id;
    end

endmodule

`default_nettype wire

// File: hdl/amp_channel.sv
`timescale 1ns/10ps
`default_nettype none

module amp_channel #(
    parameter int SAFETY_COUNT  = 10,       // consecutive overcurrent cycles to trip
    parameter int SAFETY_MARGIN = 256       // slack above twice the command
) (
    input  wire                             sysclk,
    input  wire                             rst,
    input  wire qla_bus_pkg::reg_wr_t       wr,
    input  wire qla_axis_pkg::cur_word_t    cur_fb,
    input  wire                             clear_disable,
    output qla_axis_pkg::cur_word_t         cur_cmd,
    output logic [qla_bus_pkg::DATA_W-1:0]  rdata,
    output logic                            amp_disable
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    localparam int MAG_W = CUR_W + 1;           // distance from midscale reaches 0x8000
    localparam int LIM_W = MAG_W + 2;           // doubled command plus margin
    localparam int CNT_W = $clog2(SAFETY_COUNT + 1);

    cur_word_t        cmd_q;
    logic [MAG_W-1:0] fb_mag;
    logic [MAG_W-1:0] cmd_mag;
    logic [LIM_W-1:0] limit;
    logic             over;
    logic             trip;
    logic [CNT_W-1:0] ovr_cnt;

    function automatic logic [MAG_W-1:0] mag_of(input cur_word_t v);
        logic [MAG_W-1:0] ext;
        ext = {1'b0, v};
        return (v >= CUR_MID) ? ext - MAG_W'(CUR_MID) : MAG_W'(CUR_MID) - ext;
    endfunction

    // ------------------------------------------------------------
    // command register
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cmd_q <= CUR_MID;                   // zero current
        end else if (wr.en && wr.offset == OFF_DAC_CTRL) begin
            cmd_q <= wr.data[CUR_W-1:0];
        end
    end

    assign cur_cmd = cmd_q;
    assign rdata   = DATA_W'(cmd_q);

    // ------------------------------------------------------------
    // overcurrent check, feedback above 2x command
    // ------------------------------------------------------------
    assign fb_mag  = mag_of(cur_fb);
    assign cmd_mag = mag_of(cmd_q);
    assign limit   = LIM_W'({cmd_mag, 1'b0}) + LIM_W'(SAFETY_MARGIN);
    assign over    = LIM_W'(fb_mag) > limit;
    assign trip    = over && (ovr_cnt == CNT_W'(SAFETY_COUNT - 1));

    always_ff @(posedge sysclk) begin
        if (rst) begin
            ovr_cnt     <= '0;
            amp_disable <= 1'b0;
        end else begin
            if (!over || clear_disable) begin
                ovr_cnt <= '0;                  // needs a fresh run
            end else if (!trip) begin
                ovr_cnt <= ovr_cnt + 1'b1;
            end
            if (clear_disable) begin
                amp_disable <= 1'b0;
            end else if (trip) begin
                amp_disable <= 1'b1;            // held until board_regs clears it
            end
        end
    end

    a_clear_only: assert property (@(posedge sysclk) disable iff (rst)
        $fell(amp_disable) |-> $past(clear_disable) || $past(rst));

endmodule

`default_nettype wire

// File: hdl/enc_quad.sv
`timescale 1ns/10ps
`default_nettype none

module enc_quad (
    input  wire                             sysclk,
    input  wire                             rst,
    input  wire qla_bus_pkg::reg_wr_t       wr,
    input  wire                             enc_a,
    input  wire                             enc_b,
    output qla_axis_pkg::enc_count_t        count
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    logic a_s;                  // synchronized channels
    logic b_s;
    logic a_d;                  // previous sample
    logic b_d;
    logic step;
    logic up;
    logic load;

    // ------------------------------------------------------------
    // input sync and edge history
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            // seed both stages from the pins, no phantom edge at release
            a_s <= enc_a;
            b_s <= enc_b;
            a_d <= enc_a;
            b_d <= enc_b;
        end else begin
            a_s <= enc_a;
            b_s <= enc_b;
            a_d <= a_s;
            b_d <= b_s;
        end
    end

    // x4 decode, any single edge is a count
    assign step = (a_s ^ a_d) ^ (b_s ^ b_d);
    assign up   = a_s ^ b_d;                    // set when A leads B
    assign load = wr.en && (wr.offset == OFF_ENC_LOAD);

    // ------------------------------------------------------------
    // counter
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= wr.data[ENC_W-1:0];        // preload wins over a step
        end else if (step) begin
            count <= up ? count + 1'b1 : count - 1'b1;
        end
    end

    // both channels moving together means a lost step
    a_no_double_edge: assert property (@(posedge sysclk) disable iff (rst)
        !((a_s ^ a_d) && (b_s ^ b_d)));

endmodule

`default_nettype wire

// File: hdl/qla_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module qla_ctrl_top #(
    parameter int SAFETY_COUNT  = 10,
    parameter int SAFETY_MARGIN = 256
) (
    input  wire                                 sysclk,
    input  wire                                 rst,
    input  wire qla_bus_pkg::wb_req_t           wb_req,
    output wire qla_bus_pkg::wb_rsp_t           wb_rsp,
    input  wire [qla_bus_pkg::BOARD_ID_W-1:0]   board_id,
    input  wire qla_axis_pkg::cur_word_t        cur_fb [qla_axis_pkg::NUM_AXES],
    input  wire qla_axis_pkg::axis_vec_t        enc_a,
    input  wire qla_axis_pkg::axis_vec_t        enc_b,
    output wire qla_axis_pkg::cur_word_t        cur_cmd [qla_axis_pkg::NUM_AXES],
    output wire qla_axis_pkg::axis_vec_t        amp_enable,
    output wire                                 pwr_enable
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    wire reg_wr_t     wr [NUM_AXES+1];          // channel 0 board, 1..4 axes
    wire [DATA_W-1:0] board_rdata;
    wire [DATA_W-1:0] cmd_rdata [NUM_AXES];
    wire enc_count_t  count_rdata [NUM_AXES];
    wire axis_vec_t   safety_disable;           // latched trips
    wire axis_vec_t   clear_disable;            // rearm pulses

    // ------------------------------------------------------------
    // bus slave and channel 0
    // ------------------------------------------------------------
    reg_bus_ctrl reg_bus_ctrl_i (
        .sysclk      (sysclk),
        .rst         (rst),
        .wb_req      (wb_req),
        .cur_fb      (cur_fb),
        .board_rdata (board_rdata),
        .cmd_rdata   (cmd_rdata),
        .count_rdata (count_rdata),
        .wb_rsp      (wb_rsp),
        .wr          (wr)
    );

    board_regs board_regs_i (
        .sysclk         (sysclk),
        .rst            (rst),
        .wr             (wr[0]),
        .board_id       (board_id),
        .safety_disable (safety_disable),
        .rdata          (board_rdata),
        .amp_enable     (amp_enable),
        .pwr_enable     (pwr_enable),
        .clear_disable  (clear_disable)
    );

    // ------------------------------------------------------------
    // per-axis datapaths
    // ------------------------------------------------------------
    for (genvar g = 0; g < NUM_AXES; g++) begin : g_axis
        amp_channel #(
            .SAFETY_COUNT  (SAFETY_COUNT),
            .SAFETY_MARGIN (SAFETY_MARGIN)
        ) amp_channel_i (
            .sysclk        (sysclk),
            .rst           (rst),
            .wr            (wr[g+1]),
            .cur_fb        (cur_fb[g]),
            .clear_disable (clear_disable[g]),
            .cur_cmd       (cur_cmd[g]),
            .rdata         (cmd_rdata[g]),
            .amp_disable   (safety_disable[g])
        );

        enc_quad enc_quad_i (
            .sysclk (sysclk),
            .rst    (rst),
            .wr     (wr[g+1]),
            .enc_a  (enc_a[g]),
            .enc_b  (enc_b[g]),
            .count  (count_rdata[g])
        );
    end

endmodule

`default_nettype wire

// File: verif/qla_tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module qla_tb_checker (
    input  wire                             sysclk,
    input  wire qla_bus_pkg::wb_rsp_t       wb_rsp,
    input  wire qla_axis_pkg::cur_word_t    cur_cmd [qla_axis_pkg::NUM_AXES],
    input  wire qla_axis_pkg::axis_vec_t    amp_enable,
    input  wire                             pwr_enable
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    int   checks = 0;
    int   errors = 0;
    logic ack_d  = 1'b0;            // ack at the previous falling edge

    // ------------------------------------------------------------
    // compare helpers, called from the stimulus side
    // ------------------------------------------------------------
    task automatic compare(input string name, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic check_rdata(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
        compare($sformatf("wb_rsp.dat (adr %h)", addr), wb_rsp.dat, exp);
    endtask

    task automatic check_ack(input logic exp);
        compare("wb_rsp.ack", DATA_W'(wb_rsp.ack), DATA_W'(exp));
    endtask

    task automatic check_amp(input logic [DATA_W-1:0] exp);
        compare("amp_enable", DATA_W'(amp_enable), exp);
    endtask

    task automatic check_pwr(input logic [DATA_W-1:0] exp);
        compare("pwr_enable", DATA_W'(pwr_enable), exp);
    endtask

    task automatic check_cmd(input int axis, input logic [DATA_W-1:0] exp);
        compare($sformatf("cur_cmd[%0d]", axis), DATA_W'(cur_cmd[axis]), exp);
    endtask

    // ack is a single-cycle pulse per access
    always @(negedge sysclk) begin
        if (wb_rsp.ack === 1'b1 && ack_d === 1'b1) begin
            note_failure("ack stayed high for two cycles in a row");
        end
        ack_d = wb_rsp.ack;
    end

    task automatic report();
        $display("checks %0d, errors %0d", checks, errors);
    endtask

    function automatic bit all_passed();
        return errors == 0;
    endfunction

endmodule

`default_nettype wire

// File: verif/qla_tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module qla_tb_top;

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    localparam int SAFETY_COUNT  = 8;
    localparam int SAFETY_MARGIN = 256;
    localparam int ACK_TIMEOUT   = 20;                  // cycles
    localparam int TRIP_TIMEOUT  = SAFETY_COUNT + 20;
    localparam logic [BOARD_ID_W-1:0] BOARD_ID = 4'ha;
    localparam logic [7:0] FWD_SEQ = 8'b10_11_01_00;    // {a,b} per edge, A leads
    localparam logic [7:0] REV_SEQ = 8'b01_11_10_00;    // B leads

    localparam cur_word_t CMD_VAL [NUM_AXES] = '{16'h9000, 16'h7000, 16'h8400, 16'hc000};
    localparam cur_word_t FB_VAL  [NUM_AXES] = '{16'h8123, 16'h7f00, 16'h8010, 16'h9abc};

    typedef enum logic [3:0] {
        OP_WR, OP_RD, OP_FB, OP_HOLD, OP_STEP, OP_TRIP, OP_AMP, OP_PWR, OP_CMD
    } op_t;

    // one table row
    typedef struct packed {
        op_t               op;
        logic [1:0]        axis;        // axis index where the op needs one
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;        // write data, or hold cycles
        logic [DATA_W-1:0] exp;
        cur_word_t         fb;
        int                steps;       // negative is reverse
    } row_t;

    logic                  sysclk;
    logic                  rst;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;
    logic [BOARD_ID_W-1:0] board_id;
    cur_word_t             cur_fb [NUM_AXES];
    axis_vec_t             enc_a;
    axis_vec_t             enc_b;
    cur_word_t             cur_cmd [NUM_AXES];
    axis_vec_t             amp_enable;
    logic                  pwr_enable;
    row_t                  rows [$];

    qla_ctrl_top #(
        .SAFETY_COUNT  (SAFETY_COUNT),
        .SAFETY_MARGIN (SAFETY_MARGIN)
    ) qla_ctrl_top_i (
        .sysclk     (sysclk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .board_id   (board_id),
        .cur_fb     (cur_fb),
        .enc_a      (enc_a),
        .enc_b      (enc_b),
        .cur_cmd    (cur_cmd),
        .amp_enable (amp_enable),
        .pwr_enable (pwr_enable)
    );

    qla_tb_checker qla_tb_checker_i (
        .sysclk     (sysclk),
        .wb_rsp     (wb_rsp),
        .cur_cmd    (cur_cmd),
        .amp_enable (amp_enable),
        .pwr_enable (pwr_enable)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;       // 50 MHz
    end

    // ------------------------------------------------------------
    // expected values from the register map
    // ------------------------------------------------------------
    function automatic logic [ADDR_W-1:0] reg_addr(input logic [3:0] space, input int chan,
                                                   input logic [OFF_W-1:0] off);
        return {space, 4'h0, 4'(chan), off};
    endfunction

    function automatic logic [ADDR_W-1:0] board_addr(input int chan, input logic [OFF_W-1:0] off);
        return reg_addr(ADDR_BOARD, chan, off);
    endfunction

    function automatic logic [DATA_W-1:0] status_word(input axis_vec_t amp, input axis_vec_t safe,
                                                      input logic pwr);
        return (DATA_W'(BOARD_ID) << ST_BOARD_ID_LSB) | (DATA_W'(pwr) << ST_PWR_EN)
             | (DATA_W'(safe) << ST_SAFETY_LSB) | (DATA_W'(amp) << ST_AMP_EN_LSB);
    endfunction

    function automatic logic [DATA_W-1:0] status_wr(input axis_vec_t amp, input axis_vec_t mask,
                                                    input logic pmask, input logic pen);
        return (DATA_W'(pmask) << ST_PWR_MASK) | (DATA_W'(pen) << ST_PWR_EN)
             | (DATA_W'(mask) << ST_AMP_MASK_LSB) | (DATA_W'(amp) << ST_AMP_EN_LSB);
    endfunction

    // preload + 4 per forward step - 4 per reverse step, mod 2^24
    function automatic logic [DATA_W-1:0] enc_expect(input enc_count_t pre, input int fwd,
                                                     input int rev);
        enc_count_t v;
        v = pre + ENC_W'(4 * fwd) - ENC_W'(4 * rev);
        return DATA_W'(v);
    endfunction

    // ------------------------------------------------------------
    // bus and pin drivers
    // ------------------------------------------------------------
    task automatic bus_access(input logic we, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
        int n;
        @(posedge sysclk);
        #2;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: data};
        n = 0;
        @(negedge sysclk);
        while (wb_rsp.ack !== 1'b1 && n < ACK_TIMEOUT) begin
            @(negedge sysclk);
            n++;
        end
        if (wb_rsp.ack !== 1'b1) begin
            qla_tb_checker_i.note_failure($sformatf("no ack for access to address %h", addr));
        end else if (!we) begin
            qla_tb_checker_i.check_rdata(addr, exp);    // data valid with ack
        end
        @(posedge sysclk);
        #2;
        wb_req = '0;                                    // end of cycle
    endtask

    task automatic set_fb(input int axis, input cur_word_t fb);
        @(posedge sysclk);
        #2;
        cur_fb[axis] = fb;
    endtask

    // noise stays a quarter margin above fb
    task automatic hold_noisy(input int axis, input cur_word_t fb, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge sysclk);
            #2;
            cur_fb[axis] = fb + cur_word_t'($urandom % (SAFETY_MARGIN / 4));
        end
    endtask

    task automatic enc_steps(input int axis, input int steps);
        logic [7:0] seq;
        logic [1:0] ab;
        int         n;
        seq = (steps < 0) ? REV_SEQ : FWD_SEQ;
        n   = (steps < 0) ? -steps : steps;
        for (int s = 0; s < n; s++) begin
            for (int e = 0; e < 4; e++) begin
                ab = seq[7 - 2 * e -: 2];
                @(posedge sysclk);
                #2;
                enc_a[axis] = ab[1];
                enc_b[axis] = ab[0];
                repeat (2) @(posedge sysclk);   // sync plus update
            end
        end
        repeat (3) @(posedge sysclk);
    endtask

    // starts right after the overcurrent is driven, first negedge precedes the first sample
    task automatic wait_trip(input int axis);
        int n;
        n = 0;
        while (amp_enable[axis] && n < TRIP_TIMEOUT) begin
            @(negedge sysclk);
            n++;
        end
        if (amp_enable[axis]) begin
            qla_tb_checker_i.note_failure($sformatf("axis %0d never tripped", axis));
        end else if (n != SAFETY_COUNT + 1) begin
            qla_tb_checker_i.note_failure(
                $sformatf("axis %0d tripped after %0d overcurrent cycles instead of %0d",
                          axis, n - 1, SAFETY_COUNT));
        end
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------
    task automatic add_row(input op_t op, input int axis, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp,
                           input cur_word_t fb, input int steps);
        row_t r;
        r = '{op, 2'(axis), addr, data, exp, fb, steps};
        rows.push_back(r);
    endtask

    task automatic build_table();
        // id and unmapped space
        add_row(OP_RD, 0, board_addr(0, OFF_HW_ID), '0, HW_ID, '0, 0);
        add_row(OP_RD, 0, reg_addr(4'h1, 0, OFF_HW_ID), '0, '0, '0, 0);
        add_row(OP_RD, 0, reg_addr(4'h7, 1, OFF_DAC_CTRL), '0, '0, '0, 0);
        add_row(OP_RD, 0, board_addr(0, OFF_STATUS), '0, status_word(0, 0, 0), '0, 0);
        // commands and adc readback
        for (int g = 0; g < NUM_AXES; g++) begin
            add_row(OP_WR,  g, board_addr(g + 1, OFF_DAC_CTRL), 32'(CMD_VAL[g]), '0, '0, 0);
            add_row(OP_RD,  g, board_addr(g + 1, OFF_DAC_CTRL), '0, 32'(CMD_VAL[g]), '0, 0);
            add_row(OP_CMD, g, '0, '0, 32'(CMD_VAL[g]), '0, 0);
            add_row(OP_FB,  g, '0, '0, '0, FB_VAL[g], 0);
            add_row(OP_RD,  g, board_addr(g + 1, OFF_ADC_DATA), '0, 32'(FB_VAL[g]), '0, 0);
        end
        // encoders, upper load bits dropped
        add_row(OP_WR,   0, board_addr(1, OFF_ENC_LOAD), 32'hab_fffff0, '0, '0, 0);
        add_row(OP_STEP, 0, '0, '0, '0, '0, 5);
        add_row(OP_STEP, 0, '0, '0, '0, '0, -7);
        add_row(OP_RD,   0, board_addr(1, OFF_ENC_DATA), '0, enc_expect(24'hfffff0, 5, 7), '0, 0);
        add_row(OP_WR,   2, board_addr(3, OFF_ENC_LOAD), 32'h2, '0, '0, 0);
        add_row(OP_STEP, 2, '0, '0, '0, '0, -2);
        add_row(OP_RD,   2, board_addr(3, OFF_ENC_DATA), '0, enc_expect(24'h2, 0, 2), '0, 0);
        add_row(OP_STEP, 3, '0, '0, '0, '0, 3);
        add_row(OP_RD,   3, board_addr(4, OFF_ENC_DATA), '0, enc_expect(24'h0, 3, 0), '0, 0);
        add_row(OP_RD,   1, board_addr(2, OFF_ENC_DATA), '0, '0, '0, 0);
        // status mask rules
        add_row(OP_WR,  0, board_addr(0, OFF_STATUS), status_wr(0, 0, 0, 1), '0, '0, 0);
        add_row(OP_PWR, 0, '0, '0, 32'h0, '0, 0);
        add_row(OP_WR,  0, board_addr(0, OFF_STATUS), status_wr(0, 0, 1, 1), '0, '0, 0);
        add_row(OP_PWR, 0, '0, '0, 32'h1, '0, 0);
        add_row(OP_AMP, 0, '0, '0, 32'h0, '0, 0);
        add_row(OP_WR,  0, board_addr(0, OFF_STATUS), status_wr(4'h5, 4'hf, 0, 0), '0, '0, 0);
        add_row(OP_AMP, 0, '0, '0, 32'h5, '0, 0);
        add_row(OP_WR,  0, board_addr(0, OFF_STATUS), status_wr(4'hf, 4'h2, 0, 0), '0, '0, 0);
        add_row(OP_AMP, 0, '0, '0, 32'h7, '0, 0);
        add_row(OP_RD,  0, board_addr(0, OFF_STATUS), '0, status_word(4'h7, 0, 1), '0, 0);
        add_row(OP_WR,  0, board_addr(0, OFF_STATUS), status_wr(0, 0, 1, 0), '0, '0, 0);
        add_row(OP_AMP, 0, '0, '0, 32'h0, '0, 0);
        add_row(OP_RD,  0, board_addr(0, OFF_STATUS), '0, status_word(0, 0, 0), '0, 0);
        add_row(OP_WR,  0, board_addr(0, OFF_STATUS), status_wr(0, 0, 1, 1), '0, '0, 0);
        add_row(OP_AMP, 0, '0, '0, 32'h7, '0, 0);
        // just under 2x command plus margin, never trips
        add_row(OP_HOLD, 0, '0, 4 * SAFETY_COUNT, '0, 16'ha0c0, 0);
        add_row(OP_AMP,  0, '0, '0, 32'h7, '0, 0);
        add_row(OP_FB,   0, '0, '0, '0, FB_VAL[0], 0);
        // overcurrent on axis 2, then rearm
        add_row(OP_FB,   1, '0, '0, '0, 16'h5e00, 0);
        add_row(OP_TRIP, 1, '0, '0, '0, '0, 0);
        add_row(OP_AMP,  0, '0, '0, 32'h5, '0, 0);
        add_row(OP_RD,   0, board_addr(0, OFF_STATUS), '0, status_word(4'h5, 4'h2, 1), '0, 0);
        add_row(OP_FB,   1, '0, '0, '0, FB_VAL[1], 0);
        add_row(OP_WR,   0, board_addr(0, OFF_STATUS), status_wr(4'h2, 4'h2, 0, 0), '0, '0, 0);
        add_row(OP_AMP,  0, '0, '0, 32'h7, '0, 0);
        add_row(OP_RD,   0, board_addr(0, OFF_STATUS), '0, status_word(4'h7, 0, 1), '0, 0);
    endtask

    task automatic apply_row(input row_t r);
        case (r.op)
            OP_WR:   bus_access(1'b1, r.addr, r.data, '0);
            OP_RD:   bus_access(1'b0, r.addr, '0, r.exp);
            OP_FB:   set_fb(r.axis, r.fb);
            OP_HOLD: hold_noisy(r.axis, r.fb, r.data);
            OP_STEP: enc_steps(r.axis, r.steps);
            OP_TRIP: wait_trip(r.axis);
            OP_AMP: begin
                @(negedge sysclk);
                qla_tb_checker_i.check_amp(r.exp);
            end
            OP_PWR: begin
                @(negedge sysclk);
                qla_tb_checker_i.check_pwr(r.exp);
            end
            OP_CMD: begin
                @(negedge sysclk);
                qla_tb_checker_i.check_cmd(r.axis, r.exp);
            end
            default: qla_tb_checker_i.note_failure("table row has an unknown operation");
        endcase
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'h74d7_a025));
        rst      = 1'b1;
        wb_req   = '0;
        board_id = BOARD_ID;
        enc_a    = '0;
        enc_b    = '0;
        for (int i = 0; i < NUM_AXES; i++) begin
            cur_fb[i] = CUR_MID;            // zero current
        end
        build_table();
        repeat (2) @(posedge sysclk);
        #2;
        rst = 1'b0;
        @(negedge sysclk);
        qla_tb_checker_i.check_ack(1'b0);
        qla_tb_checker_i.check_amp(32'h0);
        qla_tb_checker_i.check_pwr(32'h0);
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        repeat (4) @(posedge sysclk);
        qla_tb_checker_i.report();
        if (qla_tb_checker_i.all_passed()) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/qla_bus_pkg.sv
hdl/qla_axis_pkg.sv
hdl/reg_bus_ctrl.sv
hdl/board_regs.sv
hdl/amp_channel.sv
hdl/enc_quad.sv
hdl/qla_ctrl_top.sv
verif/qla_tb_checker.sv
verif/qla_tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, exit status follows the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module qla_tb_top -o qla_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/qla_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi

exit 0
